// File: exec_pipe.f
logic/core_pkg.sv
logic/reg_file.sv
logic/forward.sv
logic/alu.sv
logic/mem_stage.sv
logic/exec_pipe.sv
verif/exec_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench, judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module exec_pipe_tb -f exec_pipe.f -o exec_pipe_sim \
  && ./obj_dir/exec_pipe_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log \
  && { echo "Simulation reported failures"; exit 1; } \
  || { echo "Simulation finished without failures"; exit 0; }

// File: verif/exec_pipe_tb.sv
// Testbench: clock, reset, LFSR stimulus, reference model, writeback compare, closing report
module exec_pipe_tb
  import core_pkg::*;
();

  localparam int XLEN       = 64;
  localparam int MEM_WORDS  = 16;
  localparam int IDX_W      = $clog2(MEM_WORDS);
  localparam int WAIT_LIMIT = 50;
  localparam int RAND_OPS   = 400;

  logic                  clock       = 1'b0;
  logic                  reset       = 1'b1;
  logic                  issue_valid = 1'b0;
  op_e                   issue_op    = OP_ADD;
  logic [REG_ADDR_W-1:0] issue_rs1   = '0;
  logic [REG_ADDR_W-1:0] issue_rs2   = '0;
  logic [REG_ADDR_W-1:0] issue_rd    = '0;
  logic [11:0]           issue_imm   = '0;
  logic                  issue_stall;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  logic [XLEN-1:0]       model_reg [32] = '{default: '0};
  logic [XLEN-1:0]       model_mem [MEM_WORDS] = '{default: '0};
  logic [REG_ADDR_W-1:0] exp_rd_q [$];
  logic [XLEN-1:0]       exp_data_q [$];
  int                    exp_cyc_q [$];

  logic [15:0] lfsr          = 16'd60;
  int          cycle         = 0;
  int          errors        = 0;
  int          timeouts      = 0;
  int          stall_total   = 0;
  logic        check_latency = 1'b0;

  exec_pipe #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) exec_pipe_inst (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_rs1   (issue_rs1),
    .issue_rs2   (issue_rs2),
    .issue_rd    (issue_rd),
    .issue_imm   (issue_imm),
    .issue_stall (issue_stall),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [11:0] rand_bits(input int n);
    logic [11:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[10:0], lfsr[0]};
    end
    return v;
  endfunction

  // Sequential model of one accepted operation
  function automatic void model_exec(input op_e op, input logic [REG_ADDR_W-1:0] rs1,
                                     input logic [REG_ADDR_W-1:0] rs2,
                                     input logic [REG_ADDR_W-1:0] rd, input logic [11:0] imm);
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  sum;
    logic [XLEN-1:0]  res;
    logic [IDX_W-1:0] idx;
    a   = model_reg[rs1];
    b   = model_reg[rs2];
    sum = a + {{(XLEN-12){imm[11]}}, imm};
    // Word index above the byte offset, wrapped to the memory depth
    idx = IDX_W'((sum >> 3) % 64'(MEM_WORDS));
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_LOAD: res = model_mem[idx];
      default: res = sum;
    endcase
    if (op == OP_STORE) begin
      model_mem[idx] = b;
    end else begin
      if (rd != '0)
        model_reg[rd] = res;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
      exp_cyc_q.push_back(cycle);
    end
  endfunction

  task automatic check_equal(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s got %0h expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Present one operation and hold it until accepted
  task automatic send(input op_e op, input logic [REG_ADDR_W-1:0] rs1,
                      input logic [REG_ADDR_W-1:0] rs2, input logic [REG_ADDR_W-1:0] rd,
                      input logic [11:0] imm);
    int waited;
    waited = 0;
    if (timeouts > 0)
      return;
    issue_valid <= 1'b1;
    issue_op    <= op;
    issue_rs1   <= rs1;
    issue_rs2   <= rs2;
    issue_rd    <= rd;
    issue_imm   <= imm;
    @(posedge clock);
    while (issue_stall && waited < WAIT_LIMIT) begin
      stall_total++;
      waited++;
      @(posedge clock);
    end
    if (issue_stall) begin
      $display("Timeout: issue_stall stayed high and the operation was never accepted");
      timeouts++;
    end else begin
      model_exec(op, rs1, rs2, rd, imm);
    end
  endtask

  // Idle the issue port until every expected writeback has arrived
  task automatic drain();
    int waited;
    waited = 0;
    if (timeouts > 0)
      return;
    issue_valid <= 1'b0;
    while (exp_rd_q.size() != 0 && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clock);
    end
    if (exp_rd_q.size() != 0) begin
      $display("Timeout: %0d writebacks never arrived", exp_rd_q.size());
      timeouts++;
    end
  endtask

  // Compare process, outputs sampled mid-cycle
  always @(negedge clock) begin
    logic [REG_ADDR_W-1:0] erd;
    logic [XLEN-1:0]       edata;
    int                    ecyc;
    if (!reset && wb_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("Unexpected writeback to x%0d with no operation outstanding", wb_rd);
        errors++;
      end else begin
        erd   = exp_rd_q.pop_front();
        edata = exp_data_q.pop_front();
        ecyc  = exp_cyc_q.pop_front();
        check_equal("wb_rd", 64'(wb_rd), 64'(erd));
        check_equal("wb_data", wb_data, edata);
        if (check_latency)
          check_equal("writeback latency", 64'(cycle - ecyc), 64'd3);
      end
    end
  end

  initial begin
    logic [11:0] op_r;
    logic [11:0] rs1_r;
    logic [11:0] rs2_r;
    logic [11:0] rd_r;
    logic [11:0] imm_r;
    int          stalls_before;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_equal("wb_valid after reset", 64'(wb_valid), 64'd0);
    check_equal("issue_stall after reset", 64'(issue_stall), 64'd0);
    @(posedge clock);

    check_latency = 1'b1;
    send(OP_ADDI, 5'd0, 5'd0, 5'd1, 12'h011);
    send(OP_ADDI, 5'd0, 5'd0, 5'd2, 12'hf80);
    send(OP_ADDI, 5'd0, 5'd0, 5'd3, 12'h7ff);
    send(OP_ADDI, 5'd0, 5'd0, 5'd4, 12'h001);
    drain();
    check_latency = 1'b0;

    // x1 sits in memory and writeback at once for the ADD
    send(OP_ADDI, 5'd0, 5'd0, 5'd1, 12'h005);
    send(OP_ADDI, 5'd0, 5'd0, 5'd1, 12'h007);
    send(OP_ADD,  5'd1, 5'd1, 5'd2, 12'h000);
    send(OP_SUB,  5'd2, 5'd1, 5'd3, 12'h000);
    send(OP_XOR,  5'd3, 5'd2, 5'd4, 12'h000);
    send(OP_AND,  5'd4, 5'd3, 5'd5, 12'h000);
    send(OP_OR,   5'd5, 5'd3, 5'd6, 12'h000);
    drain();

    stalls_before = stall_total;
    send(OP_ADDI,  5'd0, 5'd0, 5'd1, 12'h123);
    send(OP_STORE, 5'd0, 5'd1, 5'd0, 12'h010);
    send(OP_LOAD,  5'd0, 5'd0, 5'd2, 12'h010);
    send(OP_ADD,   5'd2, 5'd1, 5'd3, 12'h000);
    // Independent op held at issue while the ADD waits for load data
    send(OP_ADDI,  5'd0, 5'd0, 5'd6, 12'h001);
    drain();
    check_equal("load-use stall cycles", 64'(stall_total - stalls_before), 64'd1);

    // Store data comes straight from the memory stage
    send(OP_ADDI,  5'd0, 5'd0, 5'd4, 12'h7ff);
    send(OP_STORE, 5'd0, 5'd4, 5'd0, 12'h028);
    send(OP_LOAD,  5'd0, 5'd0, 5'd5, 12'h028);
    drain();

    send(OP_ADDI, 5'd0, 5'd0, 5'd0, 12'h055);
    send(OP_ADD,  5'd0, 5'd0, 5'd1, 12'h000);
    send(OP_ADDI, 5'd0, 5'd0, 5'd0, 12'h066);
    send(OP_ADDI, 5'd2, 5'd0, 5'd2, 12'h001);
    send(OP_OR,   5'd0, 5'd0, 5'd3, 12'h000);
    drain();

    for (int n = 0; n < RAND_OPS; n++) begin
      op_r  = rand_bits(3);
      rs1_r = rand_bits(3);
      rs2_r = rand_bits(3);
      rd_r  = rand_bits(3);
      imm_r = rand_bits(12);
      send(op_e'(op_r[2:0]), {2'b00, rs1_r[2:0]}, {2'b00, rs2_r[2:0]},
           {2'b00, rd_r[2:0]}, imm_r);
    end
    drain();

    $display("Closing report: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: logic/exec_pipe.sv
// Datapath top: issue decode, decode/execute register, stall control, stage instances
module exec_pipe
  import core_pkg::*;
#(
  parameter int XLEN      = 64,
  parameter int MEM_WORDS = 16
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  op_e                   issue_op,
  input  logic [REG_ADDR_W-1:0] issue_rs1,
  input  logic [REG_ADDR_W-1:0] issue_rs2,
  input  logic [REG_ADDR_W-1:0] issue_rd,
  input  logic [11:0]           issue_imm,
  output logic                  issue_stall,
  output logic                  wb_valid,
  output logic [REG_ADDR_W-1:0] wb_rd,
  output logic [XLEN-1:0]       wb_data
);

  logic                  dec_use_rs1;
  logic                  dec_use_rs2;
  wb_src_e               dec_wb_src;
  logic [XLEN-1:0]       rf_rs1_data;
  logic [XLEN-1:0]       rf_rs2_data;

  logic                  ex_valid;
  wb_src_e               ex_wb_src;
  op_e                   ex_op;
  logic [REG_ADDR_W-1:0] ex_rs1;
  logic [REG_ADDR_W-1:0] ex_rs2;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [11:0]           ex_imm;
  logic [XLEN-1:0]       ex_rs1_data;
  logic [XLEN-1:0]       ex_rs2_data;
  logic                  ex_use_rs1;
  logic                  ex_use_rs2;

  logic [XLEN-1:0]       rs1_fwd;
  logic [XLEN-1:0]       rs2_fwd;
  logic                  hazard;
  logic [XLEN-1:0]       alu_result;

  logic [REG_ADDR_W-1:0] mem_rd;
  wb_src_e               mem_wb_src;
  logic [XLEN-1:0]       mem_ex_data;
  wb_src_e               wb_wb_src;
  logic [XLEN-1:0]       wb_ex_data;
  logic [XLEN-1:0]       wb_mem_data;

  // Decode
  always_comb begin
    dec_use_rs1 = 1'b1;
    dec_use_rs2 = issue_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_STORE};
    case (issue_op)
      OP_LOAD:  dec_wb_src = WB_MEM;
      OP_STORE: dec_wb_src = WB_NONE;
      default:  dec_wb_src = WB_EXE;
    endcase
  end

  assign issue_stall = hazard;

  // Decode/execute register, held while a load-use hazard is open
  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid  <= 1'b0;
      ex_wb_src <= WB_NONE;
    end else if (!hazard) begin
      ex_valid  <= issue_valid;
      ex_wb_src <= issue_valid ? dec_wb_src : WB_NONE;
    end
  end

  always_ff @(posedge clock) begin
    if (hazard) begin
      // Keep forwarded values, the writeback producer may leave this cycle
      ex_rs1_data <= rs1_fwd;
      ex_rs2_data <= rs2_fwd;
    end else if (issue_valid) begin
      ex_op       <= issue_op;
      ex_rs1      <= issue_rs1;
      ex_rs2      <= issue_rs2;
      ex_rd       <= issue_rd;
      ex_imm      <= issue_imm;
      ex_rs1_data <= rf_rs1_data;
      ex_rs2_data <= rf_rs2_data;
      ex_use_rs1  <= dec_use_rs1;
      ex_use_rs2  <= dec_use_rs2;
    end
  end

  reg_file #(.XLEN(XLEN)) reg_file_inst (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (issue_rs1),
    .rs2_addr (issue_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .wr_ena   (wb_valid),
    .wr_addr  (wb_rd),
    .wr_data  (wb_data)
  );

  forward #(.XLEN(XLEN)) forward_inst (
    .ex_rs1_addr (ex_rs1),
    .ex_rs2_addr (ex_rs2),
    .ex_rs1_data (ex_rs1_data),
    .ex_rs2_data (ex_rs2_data),
    .ex_use_rs1  (ex_valid && ex_use_rs1),
    .ex_use_rs2  (ex_valid && ex_use_rs2),
    .mem_rd      (mem_rd),
    .mem_wb_src  (mem_wb_src),
    .mem_ex_data (mem_ex_data),
    .wb_rd       (wb_rd),
    .wb_wb_src   (wb_wb_src),
    .wb_ex_data  (wb_ex_data),
    .wb_mem_data (wb_mem_data),
    .rs1_forward (rs1_fwd),
    .rs2_forward (rs2_fwd),
    .hazard      (hazard)
  );

  alu #(.XLEN(XLEN)) alu_inst (
    .op        (ex_op),
    .operand_a (rs1_fwd),
    .operand_b (rs2_fwd),
    .imm       (ex_imm),
    .result    (alu_result)
  );

  // Bubble into memory during a stall
  mem_stage #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) mem_stage_inst (
    .clock         (clock),
    .reset         (reset),
    .ex_valid      (ex_valid && !hazard),
    .ex_wb_src     (hazard ? WB_NONE : ex_wb_src),
    .ex_is_store   (ex_op == OP_STORE),
    .ex_rd         (ex_rd),
    .ex_result     (alu_result),
    .ex_store_data (rs2_fwd),
    .mem_rd        (mem_rd),
    .mem_wb_src    (mem_wb_src),
    .mem_ex_data   (mem_ex_data),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_wb_src     (wb_wb_src),
    .wb_ex_data    (wb_ex_data),
    .wb_mem_data   (wb_mem_data)
  );

  assign wb_data = (wb_wb_src == WB_MEM) ? wb_mem_data : wb_ex_data;

endmodule

// File: logic/mem_stage.sv
// Execute/memory register, data memory, memory/writeback register
module mem_stage
  import core_pkg::*;
#(
  parameter int XLEN      = 64,
  parameter int MEM_WORDS = 16
) (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  ex_valid,
  input  wb_src_e               ex_wb_src,
  input  logic                  ex_is_store,
  input  logic [REG_ADDR_W-1:0] ex_rd,
  input  logic [XLEN-1:0]       ex_result,
  input  logic [XLEN-1:0]       ex_store_data,

  output logic [REG_ADDR_W-1:0] mem_rd,
  output wb_src_e               mem_wb_src,
  output logic [XLEN-1:0]       mem_ex_data,

  output logic                  wb_valid,
  output logic [REG_ADDR_W-1:0] wb_rd,
  output wb_src_e               wb_wb_src,
  output logic [XLEN-1:0]       wb_ex_data,
  output logic [XLEN-1:0]       wb_mem_data
);

  // Byte offset within a word, then the word index above it
  localparam int OFFSET_W = $clog2(XLEN / 8);
  localparam int IDX_W    = $clog2(MEM_WORDS);

  logic              mem_valid;
  logic              mem_is_store;
  logic [XLEN-1:0]   mem_store_data;
  logic [IDX_W-1:0]  mem_index;
  logic [XLEN-1:0]   load_data;

  logic [XLEN-1:0]   dmem [MEM_WORDS];

  // Execute to memory
  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid    <= 1'b0;
      mem_wb_src   <= WB_NONE;
      mem_is_store <= 1'b0;
    end else begin
      mem_valid    <= ex_valid;
      mem_wb_src   <= ex_valid ? ex_wb_src : WB_NONE;
      mem_is_store <= ex_valid && ex_is_store;
    end
  end

  always_ff @(posedge clock) begin
    mem_rd         <= ex_rd;
    mem_ex_data    <= ex_result;
    mem_store_data <= ex_store_data;
  end

  assign mem_index = mem_ex_data[OFFSET_W +: IDX_W];
  assign load_data = dmem[mem_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (mem_valid && mem_is_store) begin
      dmem[mem_index] <= mem_store_data;
    end
  end

  // Memory to writeback, stores drop out here
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid  <= 1'b0;
      wb_wb_src <= WB_NONE;
    end else begin
      wb_valid  <= mem_valid && (mem_wb_src != WB_NONE);
      wb_wb_src <= mem_valid ? mem_wb_src : WB_NONE;
    end
  end

  always_ff @(posedge clock) begin
    wb_rd       <= mem_rd;
    wb_ex_data  <= mem_ex_data;
    wb_mem_data <= load_data;
  end

endmodule

// File: logic/alu.sv
// Execute-stage ALU, register-register ops and immediate / address add
module alu
  import core_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  op_e             op,
  input  logic [XLEN-1:0] operand_a,
  input  logic [XLEN-1:0] operand_b,
  input  logic [11:0]     imm,
  output logic [XLEN-1:0] result
);

  logic [XLEN-1:0] imm_sext;

  assign imm_sext = {{(XLEN-12){imm[11]}}, imm};

  always_comb begin
    case (op)
      OP_ADD:  result = operand_a + operand_b;
      OP_SUB:  result = operand_a - operand_b;
      OP_AND:  result = operand_a & operand_b;
      OP_OR:   result = operand_a | operand_b;
      OP_XOR:  result = operand_a ^ operand_b;
      // ADDI, and the effective address for loads and stores
      default: result = operand_a + imm_sext;
    endcase
  end

endmodule

// File: logic/forward.sv
// Execute-stage operand forwarding from memory and writeback, load-use hazard detect
module forward
  import core_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  logic [REG_ADDR_W-1:0] ex_rs1_addr,
  input  logic [REG_ADDR_W-1:0] ex_rs2_addr,
  input  logic [XLEN-1:0]       ex_rs1_data,
  input  logic [XLEN-1:0]       ex_rs2_data,
  input  logic                  ex_use_rs1,
  input  logic                  ex_use_rs2,

  input  logic [REG_ADDR_W-1:0] mem_rd,
  input  wb_src_e               mem_wb_src,
  input  logic [XLEN-1:0]       mem_ex_data,

  input  logic [REG_ADDR_W-1:0] wb_rd,
  input  wb_src_e               wb_wb_src,
  input  logic [XLEN-1:0]       wb_ex_data,
  input  logic [XLEN-1:0]       wb_mem_data,

  output logic [XLEN-1:0]       rs1_forward,
  output logic [XLEN-1:0]       rs2_forward,
  output logic                  hazard
);

  // A producer of the given kind writes the nonzero source register
  function automatic logic hits(input logic [REG_ADDR_W-1:0] src,
                                input logic [REG_ADDR_W-1:0] dst,
                                input wb_src_e               prod,
                                input wb_src_e               kind);
    return (src != '0) && (src == dst) && (prod == kind);
  endfunction

  // Newest producer first, register file value last
  function automatic logic [XLEN-1:0] pick(input logic [REG_ADDR_W-1:0] src,
                                           input logic [XLEN-1:0]       reg_data);
    if (hits(src, mem_rd, mem_wb_src, WB_EXE))
      return mem_ex_data;
    if (hits(src, wb_rd, wb_wb_src, WB_EXE))
      return wb_ex_data;
    if (hits(src, wb_rd, wb_wb_src, WB_MEM))
      return wb_mem_data;
    return reg_data;
  endfunction

  always_comb begin
    rs1_forward = pick(ex_rs1_addr, ex_rs1_data);
    rs2_forward = pick(ex_rs2_addr, ex_rs2_data);
    // Load data is not ready until writeback
    hazard = (ex_use_rs1 && hits(ex_rs1_addr, mem_rd, mem_wb_src, WB_MEM)) ||
             (ex_use_rs2 && hits(ex_rs2_addr, mem_rd, mem_wb_src, WB_MEM));
  end

endmodule

// File: logic/reg_file.sv
// Register file, 32 x XLEN, x0 reads zero, write-first bypass on both read ports
module reg_file
  import core_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  logic                  wr_ena,
  input  logic [REG_ADDR_W-1:0] wr_addr,
  input  logic [XLEN-1:0]       wr_data
);

  logic [XLEN-1:0] regs [1:31];

  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    if (addr == '0)
      return '0;
    // Same-cycle writeback wins over the stored value
    if (wr_ena && (wr_addr == addr))
      return wr_data;
    return regs[addr];
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

// File: logic/core_pkg.sv
// Shared opcode and writeback-source types, register address width
package core_pkg;

  // Register file has 32 entries
  localparam int REG_ADDR_W = 5;

  // Operations accepted on the issue port
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_XOR   = 3'd4,
    OP_ADDI  = 3'd5,
    OP_LOAD  = 3'd6,
    OP_STORE = 3'd7
  } op_e;

  // Source of the value written back to rd
  // WB_NONE marks stores and bubbles, so nothing downstream writes or forwards
  typedef enum logic [1:0] {
    WB_NONE = 2'd0,
    WB_EXE  = 2'd1,
    WB_MEM  = 2'd2
  } wb_src_e;

endpackage
